// ==== axil_demux_params.svh ====
// AXI4-Lite demux parameters
// port count, order FIFO depth and bus widths shared by all blocks

`ifndef AXIL_DEMUX_PARAMS_SVH
`define AXIL_DEMUX_PARAMS_SVH

// manager side fan-out, must be a power of two
`define AXIL_NUM_PORTS 4

`define AXIL_MAX_TRANS 4 // depth of every order FIFO

`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32

// select exactly covers the port count
`define AXIL_SEL_W ($clog2(`AXIL_NUM_PORTS))

`endif

// ==== axil_demux_pkg.sv ====
// AXI4-Lite demux shared types
// vector typedefs for the bus fields and the AW lock state

`include "axil_demux_params.svh"

package axil_demux_pkg;

  // ------------------------------
  // bus field types
  // ------------------------------
  typedef logic [`AXIL_ADDR_W-1:0]   addr_t;
  typedef logic [`AXIL_DATA_W-1:0]   data_t;
  typedef logic [`AXIL_DATA_W/8-1:0] strb_t; // one bit per byte lane
  typedef logic [1:0]                resp_t; // OKAY, EXOKAY, SLVERR, DECERR

  // manager port index
  typedef logic [`AXIL_SEL_W-1:0] sel_t;

  // ------------------------------
  // AW lock FSM
  // ------------------------------
  // locked means the select is already in the W FIFO
  // and the port has not yet taken the request
  typedef enum logic {
    aw_idle,
    aw_locked
  } aw_state_e;

endpackage

// ==== axil_spill_reg.sv ====
// Two-entry spill register
// cuts the combinational ready path between its two sides,
// ready_o only looks at the local fill state

`timescale 1ns/1ns

module axil_spill_reg
  import axil_demux_pkg::*;
#(
  parameter int unsigned WIDTH = $bits(addr_t) + $bits(sel_t) // address plus select
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [WIDTH-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [WIDTH-1:0] data_o
);

  logic             a_full_q, b_full_q;
  logic [WIDTH-1:0] a_data_q, b_data_q;
  logic             a_fill, a_drain;
  logic             b_fill, b_drain;

  // main slot takes new input, spill slot catches a stalled main entry
  assign a_fill  = valid_i & ready_o;
  assign a_drain = a_full_q & ~b_full_q;
  assign b_fill  = a_drain & ~ready_i; // output stalled, park it
  assign b_drain = b_full_q & ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) a_full_q <= a_fill;
      if (b_fill || b_drain) b_full_q <= b_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= data_i;
    if (b_fill) b_data_q <= a_data_q;
  end

  // spill slot is always the older entry
  assign valid_o = a_full_q | b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;
  assign ready_o = ~a_full_q | ~b_full_q;

endmodule

// ==== axil_sel_fifo.sv ====
// Port select FIFO
// circular buffer that keeps the order of issued transactions,
// push and pop may happen in the same cycle

`timescale 1ns/1ns
`include "axil_demux_params.svh"

module axil_sel_fifo
  import axil_demux_pkg::*;
#(
  parameter int unsigned DEPTH = `AXIL_MAX_TRANS
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic push_i,
  input  sel_t data_i,
  input  logic pop_i,
  output sel_t data_o,
  output logic full_o,
  output logic empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [PTR_W:0]   count_q;
  sel_t             mem_q [DEPTH];

  // wrap at DEPTH, not only at a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop_i)  rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // both or none
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= data_i;
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign full_o  = (count_q == (PTR_W + 1)'(DEPTH));
  assign empty_o = (count_q == '0);

endmodule

// ==== axil_write_router.sv ====
// AXI4-Lite write router
// steers AW to its selected port, then keeps W and B in issue
// order with a W select FIFO followed by a B select FIFO

`timescale 1ns/1ns
`include "axil_demux_params.svh"

module axil_write_router
  import axil_demux_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  // AW from the spill register
  input  logic                             aw_valid_i,
  output logic                             aw_ready_o,
  input  sel_t                             aw_sel_i,
  output logic  [`AXIL_NUM_PORTS-1:0]      m_aw_valid_o,
  input  logic  [`AXIL_NUM_PORTS-1:0]      m_aw_ready_i,
  // W
  input  logic                             s_w_valid_i,
  output logic                             s_w_ready_o,
  output logic  [`AXIL_NUM_PORTS-1:0]      m_w_valid_o,
  input  logic  [`AXIL_NUM_PORTS-1:0]      m_w_ready_i,
  // B
  output logic                             s_b_valid_o,
  input  logic                             s_b_ready_i,
  output resp_t                            s_b_resp_o,
  input  logic  [`AXIL_NUM_PORTS-1:0]      m_b_valid_i,
  output logic  [`AXIL_NUM_PORTS-1:0]      m_b_ready_o,
  input  resp_t [`AXIL_NUM_PORTS-1:0]      m_b_resp_i
);

  aw_state_e aw_state_q, aw_state_d;

  logic w_fifo_push, w_fifo_pop;
  logic w_fifo_full, w_fifo_empty;
  logic b_fifo_pop;
  logic b_fifo_full, b_fifo_empty;
  logic w_go;
  sel_t w_sel, b_sel;

  // ------------------------------
  // AW lock
  // ------------------------------
  always_comb begin
    aw_state_d   = aw_state_q;
    aw_ready_o   = 1'b0;
    m_aw_valid_o = '0;
    w_fifo_push  = 1'b0;
    case (aw_state_q)
      aw_idle: begin
        // only show the request when its select fits in the W FIFO
        if (aw_valid_i && !w_fifo_full) begin
          w_fifo_push            = 1'b1;
          m_aw_valid_o[aw_sel_i] = 1'b1;
          if (m_aw_ready_i[aw_sel_i]) begin
            aw_ready_o = 1'b1;
          end else begin
            aw_state_d = aw_locked; // port stalls, select already pushed
          end
        end
      end
      aw_locked: begin
        m_aw_valid_o[aw_sel_i] = 1'b1;
        if (m_aw_ready_i[aw_sel_i]) begin
          aw_ready_o = 1'b1;
          aw_state_d = aw_idle;
        end
      end
      default: aw_state_d = aw_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      aw_state_q <= aw_idle;
    end else begin
      aw_state_q <= aw_state_d;
    end
  end

  axil_sel_fifo #(
    .DEPTH   (`AXIL_MAX_TRANS)
  ) w_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (w_fifo_push),
    .data_i  (aw_sel_i),
    .pop_i   (w_fifo_pop),
    .data_o  (w_sel),
    .full_o  (w_fifo_full),
    .empty_o (w_fifo_empty)
  );

  // ------------------------------
  // W steering
  // ------------------------------
  // W waits for its select and for room to record the B order
  assign w_go        = ~w_fifo_empty & ~b_fifo_full;
  assign s_w_ready_o = w_go & m_w_ready_i[w_sel];
  assign w_fifo_pop  = s_w_valid_i & s_w_ready_o; // also the B FIFO push

  for (genvar i = 0; i < `AXIL_NUM_PORTS; i++) begin : gen_w_valid
    assign m_w_valid_o[i] = w_go & s_w_valid_i & (w_sel == sel_t'(i));
  end

  axil_sel_fifo #(
    .DEPTH   (`AXIL_MAX_TRANS)
  ) b_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (w_fifo_pop),
    .data_i  (w_sel),
    .pop_i   (b_fifo_pop),
    .data_o  (b_sel),
    .full_o  (b_fifo_full),
    .empty_o (b_fifo_empty)
  );

  // ------------------------------
  // B steering
  // ------------------------------
  assign s_b_valid_o = ~b_fifo_empty & m_b_valid_i[b_sel];
  assign s_b_resp_o  = m_b_resp_i[b_sel];
  assign b_fifo_pop  = s_b_valid_o & s_b_ready_i;

  for (genvar i = 0; i < `AXIL_NUM_PORTS; i++) begin : gen_b_ready
    assign m_b_ready_o[i] = ~b_fifo_empty & s_b_ready_i & (b_sel == sel_t'(i));
  end

endmodule

// ==== axil_read_router.sv ====
// AXI4-Lite read router
// steers AR to its selected port and returns R from the ports
// in issue order through one select FIFO

`timescale 1ns/1ns
`include "axil_demux_params.svh"

module axil_read_router
  import axil_demux_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // AR from the spill register
  input  logic                        ar_valid_i,
  output logic                        ar_ready_o,
  input  sel_t                        ar_sel_i,
  output logic  [`AXIL_NUM_PORTS-1:0] m_ar_valid_o,
  input  logic  [`AXIL_NUM_PORTS-1:0] m_ar_ready_i,
  // R
  output logic                        s_r_valid_o,
  input  logic                        s_r_ready_i,
  output data_t                       s_r_data_o,
  output resp_t                       s_r_resp_o,
  input  logic  [`AXIL_NUM_PORTS-1:0] m_r_valid_i,
  output logic  [`AXIL_NUM_PORTS-1:0] m_r_ready_o,
  input  data_t [`AXIL_NUM_PORTS-1:0] m_r_data_i,
  input  resp_t [`AXIL_NUM_PORTS-1:0] m_r_resp_i
);

  logic r_fifo_push, r_fifo_pop;
  logic r_fifo_full, r_fifo_empty;
  sel_t r_sel;

  // ------------------------------
  // AR steering
  // ------------------------------
  // a full FIFO keeps the request hidden from every port
  assign ar_ready_o  = ~r_fifo_full & m_ar_ready_i[ar_sel_i];
  assign r_fifo_push = ar_valid_i & ar_ready_o;

  for (genvar i = 0; i < `AXIL_NUM_PORTS; i++) begin : gen_ar_valid
    assign m_ar_valid_o[i] = ~r_fifo_full & ar_valid_i & (ar_sel_i == sel_t'(i));
  end

  axil_sel_fifo #(
    .DEPTH   (`AXIL_MAX_TRANS)
  ) r_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (r_fifo_push),
    .data_i  (ar_sel_i),
    .pop_i   (r_fifo_pop),
    .data_o  (r_sel),
    .full_o  (r_fifo_full),
    .empty_o (r_fifo_empty)
  );

  // ------------------------------
  // R steering
  // ------------------------------
  assign s_r_valid_o = ~r_fifo_empty & m_r_valid_i[r_sel]; // head port only
  assign s_r_data_o  = m_r_data_i[r_sel];
  assign s_r_resp_o  = m_r_resp_i[r_sel];
  assign r_fifo_pop  = s_r_valid_o & s_r_ready_i;

  for (genvar i = 0; i < `AXIL_NUM_PORTS; i++) begin : gen_r_ready
    assign m_r_ready_o[i] = ~r_fifo_empty & s_r_ready_i & (r_sel == sel_t'(i));
  end

endmodule

// ==== axil_demux.sv ====
// AXI4-Lite demultiplexer
// one subordinate-side port fanned out to NUM_PORTS manager ports,
// AW and AR go through spill registers before the routers

`timescale 1ns/1ns
`include "axil_demux_params.svh"

module axil_demux
  import axil_demux_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // subordinate side
  input  logic                        s_aw_valid_i,
  output logic                        s_aw_ready_o,
  input  addr_t                       s_aw_addr_i,
  input  sel_t                        s_aw_sel_i,
  input  logic                        s_w_valid_i,
  output logic                        s_w_ready_o,
  input  data_t                       s_w_data_i,
  input  strb_t                       s_w_strb_i,
  output logic                        s_b_valid_o,
  input  logic                        s_b_ready_i,
  output resp_t                       s_b_resp_o,
  input  logic                        s_ar_valid_i,
  output logic                        s_ar_ready_o,
  input  addr_t                       s_ar_addr_i,
  input  sel_t                        s_ar_sel_i,
  output logic                        s_r_valid_o,
  input  logic                        s_r_ready_i,
  output data_t                       s_r_data_o,
  output resp_t                       s_r_resp_o,
  // manager side
  output logic  [`AXIL_NUM_PORTS-1:0] m_aw_valid_o,
  input  logic  [`AXIL_NUM_PORTS-1:0] m_aw_ready_i,
  output addr_t                       m_aw_addr_o,
  output logic  [`AXIL_NUM_PORTS-1:0] m_w_valid_o,
  input  logic  [`AXIL_NUM_PORTS-1:0] m_w_ready_i,
  output data_t                       m_w_data_o,
  output strb_t                       m_w_strb_o,
  input  logic  [`AXIL_NUM_PORTS-1:0] m_b_valid_i,
  output logic  [`AXIL_NUM_PORTS-1:0] m_b_ready_o,
  input  resp_t [`AXIL_NUM_PORTS-1:0] m_b_resp_i,
  output logic  [`AXIL_NUM_PORTS-1:0] m_ar_valid_o,
  input  logic  [`AXIL_NUM_PORTS-1:0] m_ar_ready_i,
  output addr_t                       m_ar_addr_o,
  input  logic  [`AXIL_NUM_PORTS-1:0] m_r_valid_i,
  output logic  [`AXIL_NUM_PORTS-1:0] m_r_ready_o,
  input  data_t [`AXIL_NUM_PORTS-1:0] m_r_data_i,
  input  resp_t [`AXIL_NUM_PORTS-1:0] m_r_resp_i
);

  localparam int unsigned REQ_W = $bits(addr_t) + $bits(sel_t);

  logic             aw_valid, aw_ready;
  logic             ar_valid, ar_ready;
  logic [REQ_W-1:0] aw_req, ar_req; // {addr, sel}
  sel_t             aw_sel, ar_sel;

  // ------------------------------
  // request spill registers
  // ------------------------------
  axil_spill_reg #(.WIDTH(REQ_W)) aw_spill (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (s_aw_valid_i),
    .ready_o (s_aw_ready_o),
    .data_i  ({s_aw_addr_i, s_aw_sel_i}),
    .valid_o (aw_valid),
    .ready_i (aw_ready),
    .data_o  (aw_req)
  );

  axil_spill_reg #(.WIDTH(REQ_W)) ar_spill (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (s_ar_valid_i),
    .ready_o (s_ar_ready_o),
    .data_i  ({s_ar_addr_i, s_ar_sel_i}),
    .valid_o (ar_valid),
    .ready_i (ar_ready),
    .data_o  (ar_req)
  );

  // payloads go to every port, the valids pick one
  assign {m_aw_addr_o, aw_sel} = aw_req;
  assign {m_ar_addr_o, ar_sel} = ar_req;
  assign m_w_data_o            = s_w_data_i;
  assign m_w_strb_o            = s_w_strb_i;

  // ------------------------------
  // routers
  // ------------------------------
  axil_write_router write_router (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .aw_valid_i   (aw_valid),
    .aw_ready_o   (aw_ready),
    .aw_sel_i     (aw_sel),
    .m_aw_valid_o (m_aw_valid_o),
    .m_aw_ready_i (m_aw_ready_i),
    .s_w_valid_i  (s_w_valid_i),
    .s_w_ready_o  (s_w_ready_o),
    .m_w_valid_o  (m_w_valid_o),
    .m_w_ready_i  (m_w_ready_i),
    .s_b_valid_o  (s_b_valid_o),
    .s_b_ready_i  (s_b_ready_i),
    .s_b_resp_o   (s_b_resp_o),
    .m_b_valid_i  (m_b_valid_i),
    .m_b_ready_o  (m_b_ready_o),
    .m_b_resp_i   (m_b_resp_i)
  );

  axil_read_router read_router (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .ar_valid_i   (ar_valid),
    .ar_ready_o   (ar_ready),
    .ar_sel_i     (ar_sel),
    .m_ar_valid_o (m_ar_valid_o),
    .m_ar_ready_i (m_ar_ready_i),
    .s_r_valid_o  (s_r_valid_o),
    .s_r_ready_i  (s_r_ready_i),
    .s_r_data_o   (s_r_data_o),
    .s_r_resp_o   (s_r_resp_o),
    .m_r_valid_i  (m_r_valid_i),
    .m_r_ready_o  (m_r_ready_o),
    .m_r_data_i   (m_r_data_i),
    .m_r_resp_i   (m_r_resp_i)
  );

endmodule

// ==== tb_clock_gen.sv ====
// Testbench clock and reset
// free running clock, active low reset held for a few cycles

`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS    = 100,
  parameter int unsigned RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release a little after the edge, like every other input
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #10;
    rst_n_o = 1'b1;
  end

endmodule

// ==== tb_axil_demux_asserts.sv ====
// AXI4-Lite demux assertions
// one-hot request valids, stable requests under stall,
// and no push into a full order FIFO

`timescale 1ns/1ns
`include "axil_demux_params.svh"

module tb_axil_demux_asserts
  import axil_demux_pkg::*;
(
  input logic                       clk_i,
  input logic                       rst_n_i,
  input logic [`AXIL_NUM_PORTS-1:0] aw_valid_i,
  input logic [`AXIL_NUM_PORTS-1:0] aw_ready_i,
  input addr_t                      aw_addr_i,
  input logic [`AXIL_NUM_PORTS-1:0] ar_valid_i,
  input logic [`AXIL_NUM_PORTS-1:0] ar_ready_i,
  input addr_t                      ar_addr_i,
  input logic                       w_push_i,
  input logic                       w_full_i,
  input logic                       b_push_i,
  input logic                       b_full_i,
  input logic                       r_push_i,
  input logic                       r_full_i
);

  // ------------------------------
  // request channels
  // ------------------------------
  a_aw_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(aw_valid_i)) else $error("AW valid raised on more than one port");

  a_ar_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(ar_valid_i)) else $error("AR valid raised on more than one port");

  // a stalled request keeps its port and address
  a_aw_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (aw_valid_i != '0 && (aw_valid_i & aw_ready_i) == '0) |=>
    (aw_valid_i == $past(aw_valid_i) && aw_addr_i == $past(aw_addr_i)))
    else $error("AW request dropped or changed before ready");

  a_ar_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ar_valid_i != '0 && (ar_valid_i & ar_ready_i) == '0) |=>
    (ar_valid_i == $past(ar_valid_i) && ar_addr_i == $past(ar_addr_i)))
    else $error("AR request dropped or changed before ready");

  // ------------------------------
  // order FIFOs
  // ------------------------------
  a_w_push: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(w_push_i && w_full_i)) else $error("push into full W FIFO");

  a_b_push: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(b_push_i && b_full_i)) else $error("push into full B FIFO");

  a_r_push: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(r_push_i && r_full_i)) else $error("push into full R FIFO");

endmodule

// ==== tb_axil_demux.sv ====
// AXI4-Lite demux testbench
// random writes and reads against four in-order port models,
// every transfer checked against a queue model of issued requests

`timescale 1ns/1ns
`include "axil_demux_params.svh"

module tb_axil_demux
  import axil_demux_pkg::*;
();

  localparam int NP      = `AXIL_NUM_PORTS;
  localparam int NUM_WR  = 300;
  localparam int NUM_RD  = 300;
  localparam int MAX_CYC = 20000;
  localparam int MEM_D   = 8; // read slots per port model

  logic                clk_i;
  logic                rst_n_i;
  logic                s_aw_valid_i;
  logic                s_aw_ready_o;
  addr_t               s_aw_addr_i;
  sel_t                s_aw_sel_i;
  logic                s_w_valid_i;
  logic                s_w_ready_o;
  data_t               s_w_data_i;
  strb_t               s_w_strb_i;
  logic                s_b_valid_o;
  logic                s_b_ready_i;
  resp_t               s_b_resp_o;
  logic                s_ar_valid_i;
  logic                s_ar_ready_o;
  addr_t               s_ar_addr_i;
  sel_t                s_ar_sel_i;
  logic                s_r_valid_o;
  logic                s_r_ready_i;
  data_t               s_r_data_o;
  resp_t               s_r_resp_o;
  logic       [NP-1:0] m_aw_valid_o;
  logic       [NP-1:0] m_aw_ready_i;
  addr_t               m_aw_addr_o;
  logic       [NP-1:0] m_w_valid_o;
  logic       [NP-1:0] m_w_ready_i;
  data_t               m_w_data_o;
  strb_t               m_w_strb_o;
  logic       [NP-1:0] m_b_valid_i;
  logic       [NP-1:0] m_b_ready_o;
  resp_t      [NP-1:0] m_b_resp_i;
  logic       [NP-1:0] m_ar_valid_o;
  logic       [NP-1:0] m_ar_ready_i;
  addr_t               m_ar_addr_o;
  logic       [NP-1:0] m_r_valid_i;
  logic       [NP-1:0] m_r_ready_o;
  data_t      [NP-1:0] m_r_data_i;
  resp_t      [NP-1:0] m_r_resp_i;

  // expected traffic in issue order
  sel_t  aw_sel_q[$];
  addr_t aw_addr_q[$];
  sel_t  w_sel_q[$];
  data_t w_data_q[$];
  strb_t w_strb_q[$];
  resp_t b_resp_q[$];
  sel_t  ar_sel_q[$];
  addr_t ar_addr_q[$];
  data_t r_data_q[$];

  // port model state
  int    aw_acc [NP];
  int    w_acc  [NP];
  int    b_done [NP];
  int    ar_acc [NP];
  int    r_done [NP];
  addr_t rd_mem [NP][MEM_D];

  logic [31:0] lfsr_q;
  logic        aw_busy, w_busy, ar_busy; // subordinate valids held
  int          wr_issued, rd_issued;
  int          aw_xfer, ar_xfer, b_cnt, r_cnt;

  tb_clock_gen clock_gen (
    .clk_o   (clk_i),
    .rst_n_o (rst_n_i)
  );

  axil_demux axil_demux_i (.*);

  bind axil_demux tb_axil_demux_asserts asserts_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .aw_valid_i (m_aw_valid_o),
    .aw_ready_i (m_aw_ready_i),
    .aw_addr_i  (m_aw_addr_o),
    .ar_valid_i (m_ar_valid_o),
    .ar_ready_i (m_ar_ready_i),
    .ar_addr_i  (m_ar_addr_o),
    .w_push_i   (write_router.w_fifo_push),
    .w_full_i   (write_router.w_fifo_full),
    .b_push_i   (write_router.w_fifo_pop),
    .b_full_i   (write_router.b_fifo_full),
    .r_push_i   (read_router.r_fifo_push),
    .r_full_i   (read_router.r_fifo_full)
  );

  // ------------------------------
  // random numbers
  // ------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 32'h80200003;
    return n;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      r      = {r[30:0], lfsr_q[0]}; // one step per bit
    end
    return r;
  endfunction

  function automatic sel_t port_of(input logic [NP-1:0] v);
    sel_t idx;
    idx = '0;
    for (int i = 0; i < NP; i++) begin
      if (v[i]) idx = sel_t'(i);
    end
    return idx;
  endfunction

  // ------------------------------
  // checks
  // ------------------------------
  task automatic fail_now(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) fail_now($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic compare_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) fail_now($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic compare_strb(input string name, input strb_t got, input strb_t exp);
    if (got !== exp) fail_now($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic compare_resp(input string name, input resp_t got, input resp_t exp);
    if (got !== exp) fail_now($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic compare_sel(input string name, input sel_t got, input sel_t exp);
    if (got !== exp) fail_now($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic compare_flags(input string name, input logic [NP-1:0] got,
                               input logic [NP-1:0] exp);
    if (got !== exp) fail_now($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_idle();
    compare_flags("m_aw_valid_o", m_aw_valid_o, '0);
    compare_flags("m_w_valid_o", m_w_valid_o, '0);
    compare_flags("m_ar_valid_o", m_ar_valid_o, '0);
    compare_flags("s_b_valid_o", NP'(s_b_valid_o), '0);
    compare_flags("s_r_valid_o", NP'(s_r_valid_o), '0);
  endtask

  // ------------------------------
  // stimulus and port models
  // ------------------------------
  task automatic drive_inputs();
    sel_t p;
    if (!aw_busy && wr_issued < NUM_WR && rand_bits(1) != 0) begin
      s_aw_sel_i  = sel_t'(rand_bits(`AXIL_SEL_W));
      s_aw_addr_i = addr_t'(rand_bits(32));
      aw_sel_q.push_back(s_aw_sel_i);
      aw_addr_q.push_back(s_aw_addr_i);
      w_sel_q.push_back(s_aw_sel_i);
      w_data_q.push_back(data_t'(rand_bits(32)));
      w_strb_q.push_back(strb_t'(rand_bits(4)));
      b_resp_q.push_back(resp_t'(int'(s_aw_sel_i) % 4)); // port index mod 4
      aw_busy   = 1'b1;
      wr_issued++;
    end
    if (!w_busy && w_data_q.size() > 0 && rand_bits(1) != 0) w_busy = 1'b1;
    if (w_busy) begin
      s_w_data_i = w_data_q[0];
      s_w_strb_i = w_strb_q[0];
    end
    if (!ar_busy && rd_issued < NUM_RD && rand_bits(1) != 0) begin
      s_ar_sel_i  = sel_t'(rand_bits(`AXIL_SEL_W));
      s_ar_addr_i = addr_t'(rand_bits(32));
      ar_sel_q.push_back(s_ar_sel_i);
      ar_addr_q.push_back(s_ar_addr_i);
      r_data_q.push_back(s_ar_addr_i ^ (data_t'(s_ar_sel_i) * 32'h01010101));
      ar_busy   = 1'b1;
      rd_issued++;
    end
    s_aw_valid_i = aw_busy;
    s_w_valid_i  = w_busy;
    s_ar_valid_i = ar_busy;
    s_b_ready_i  = (rand_bits(1) != 0);
    s_r_ready_i  = (rand_bits(1) != 0);
    m_aw_ready_i = NP'(rand_bits(NP));
    m_w_ready_i  = NP'(rand_bits(NP));
    m_ar_ready_i = NP'(rand_bits(NP));
    // in-order subordinates, B once both AW and W are in
    for (int i = 0; i < NP; i++) begin
      p              = sel_t'(i);
      m_b_valid_i[p] = ((aw_acc[p] < w_acc[p]) ? aw_acc[p] : w_acc[p]) > b_done[p];
      m_b_resp_i[p]  = resp_t'(i % 4);
      m_r_valid_i[p] = ar_acc[p] > r_done[p];
      m_r_data_i[p]  = rd_mem[p][3'(r_done[p])] ^ (data_t'(i) * 32'h01010101);
      m_r_resp_i[p]  = m_r_valid_i[p] ? 2'b00 : 2'b10; // SLVERR on idle ports
    end
  endtask

  // sampled mid-cycle, the transfers of the coming edge
  task automatic sample_outputs();
    logic [NP-1:0] hs;
    sel_t          p;
    hs = m_aw_valid_o & m_aw_ready_i;
    if (hs != '0) begin
      if ($countones(hs) != 1) fail_now("AW transferred on more than one port");
      if (aw_sel_q.size() == 0) fail_now("AW transfer with no write pending");
      p = port_of(hs);
      compare_sel("m_aw port", p, aw_sel_q.pop_front());
      compare_addr("m_aw_addr_o", m_aw_addr_o, aw_addr_q.pop_front());
      aw_acc[p]++;
      aw_xfer++;
    end
    if (s_aw_valid_i && s_aw_ready_o) aw_busy = 1'b0;

    hs = m_w_valid_o & m_w_ready_i;
    if ((hs != '0) != (s_w_valid_i && s_w_ready_o)) begin
      fail_now("W transfer seen on only one side of the demux");
    end
    if (hs != '0) begin
      if ($countones(hs) != 1) fail_now("W transferred on more than one port");
      p = port_of(hs);
      compare_sel("m_w port", p, w_sel_q.pop_front());
      compare_data("m_w_data_o", m_w_data_o, w_data_q.pop_front());
      compare_strb("m_w_strb_o", m_w_strb_o, w_strb_q.pop_front());
      w_acc[p]++;
      w_busy = 1'b0;
    end

    hs = m_b_valid_i & m_b_ready_o;
    if ((hs != '0) != (s_b_valid_o && s_b_ready_i)) begin
      fail_now("B transfer seen on only one side of the demux");
    end
    if (hs != '0) begin
      if (b_resp_q.size() == 0) fail_now("B response with no write outstanding");
      compare_resp("s_b_resp_o", s_b_resp_o, b_resp_q.pop_front());
      b_done[port_of(hs)]++;
      b_cnt++;
    end

    hs = m_ar_valid_o & m_ar_ready_i;
    if (hs != '0) begin
      if ($countones(hs) != 1) fail_now("AR transferred on more than one port");
      if (ar_sel_q.size() == 0) fail_now("AR transfer with no read pending");
      p = port_of(hs);
      compare_sel("m_ar port", p, ar_sel_q.pop_front());
      compare_addr("m_ar_addr_o", m_ar_addr_o, ar_addr_q.pop_front());
      rd_mem[p][3'(ar_acc[p])] = m_ar_addr_o;
      ar_acc[p]++;
      ar_xfer++;
    end
    if (s_ar_valid_i && s_ar_ready_o) ar_busy = 1'b0;

    hs = m_r_valid_i & m_r_ready_o;
    if ((hs != '0) != (s_r_valid_o && s_r_ready_i)) begin
      fail_now("R transfer seen on only one side of the demux");
    end
    if (hs != '0) begin
      if (r_data_q.size() == 0) fail_now("R response with no read outstanding");
      compare_data("s_r_data_o", s_r_data_o, r_data_q.pop_front());
      compare_resp("s_r_resp_o", s_r_resp_o, 2'b00);
      r_done[port_of(hs)]++;
      r_cnt++;
    end

    if (aw_xfer - b_cnt > 2 * `AXIL_MAX_TRANS) fail_now("too many writes outstanding");
    if (ar_xfer - r_cnt > `AXIL_MAX_TRANS) fail_now("too many reads outstanding");
  endtask

  task automatic run_cycle();
    @(posedge clk_i);
    #10;
    drive_inputs();
    @(negedge clk_i);
    sample_outputs();
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    int cycles;
    lfsr_q       = 32'hf390e9c9;
    s_aw_valid_i = 1'b0;
    s_aw_addr_i  = '0;
    s_aw_sel_i   = '0;
    s_w_valid_i  = 1'b0;
    s_w_data_i   = '0;
    s_w_strb_i   = '0;
    s_b_ready_i  = 1'b0;
    s_ar_valid_i = 1'b0;
    s_ar_addr_i  = '0;
    s_ar_sel_i   = '0;
    s_r_ready_i  = 1'b0;
    m_aw_ready_i = '0;
    m_w_ready_i  = '0;
    m_b_valid_i  = '0;
    m_b_resp_i   = '0;
    m_ar_ready_i = '0;
    m_r_valid_i  = '0;
    m_r_data_i   = '0;
    m_r_resp_i   = '0;
    aw_busy      = 1'b0;
    w_busy       = 1'b0;
    ar_busy      = 1'b0;
    wr_issued    = 0;
    rd_issued    = 0;
    aw_xfer      = 0;
    ar_xfer      = 0;
    b_cnt        = 0;
    r_cnt        = 0;
    aw_acc       = '{default: 0};
    w_acc        = '{default: 0};
    b_done       = '{default: 0};
    ar_acc       = '{default: 0};
    r_done       = '{default: 0};
    rd_mem       = '{default: '{default: '0}};

    // quiet through reset and the first cycle after it
    cycles = 0;
    do begin
      @(negedge clk_i);
      check_idle();
      cycles++;
      if (cycles > 10) fail_now("timeout waiting for reset release");
    end while (!rst_n_i);

    cycles = 0;
    while (b_cnt < NUM_WR || r_cnt < NUM_RD) begin
      run_cycle();
      cycles++;
      if (cycles > MAX_CYC) fail_now("timeout waiting for all responses");
    end

    if (aw_xfer == NUM_WR && ar_xfer == NUM_RD && aw_sel_q.size() == 0 &&
        w_sel_q.size() == 0 && b_resp_q.size() == 0 && r_data_q.size() == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      fail_now("requests left in the model after all responses arrived");
    end
  end

endmodule

// ==== axil_demux.f ====
+incdir+.
axil_demux_pkg.sv
axil_spill_reg.sv
axil_sel_fifo.sv
axil_write_router.sv
axil_read_router.sv
axil_demux.sv
tb_clock_gen.sv
tb_axil_demux_asserts.sv
tb_axil_demux.sv

// ==== Makefile ====
# tool, flags, top module and file list
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_axil_demux
FILELIST  = axil_demux.f
LOG       = sim.log

.PHONY: sim clean

# the log decides pass or fail
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
